// File: flist.f
+incdir+hw
+incdir+test
hw/matmul_pkg.sv
hw/matmul_ifs.sv
hw/seq_counter.sv
hw/matmul_ctrl.sv
hw/operand_loader.sv
hw/dot_product_array.sv
hw/result_text.sv
hw/byte_credit_tx.sv
hw/matmul_top.sv
test/tb_matmul_top.sv

// File: hw/byte_credit_tx.sv
`default_nettype none

`include "matmul_macros.svh"

module byte_credit_tx (
  input  wire logic       clk,
  input  wire logic       reset_n,
  input  wire logic       send,
  input  wire logic [7:0] char_in,
  input  wire logic       tx_credit,   // one pulse per returned credit
  output logic            can_send,
  output logic            tx_valid,
  output logic [7:0]      tx_data
);

  localparam int CW = $clog2(`MM_TX_CREDITS + 1);

  logic [CW-1:0] credits;

  // the byte already in the output register still owns one credit
  assign can_send = (credits > CW'(tx_valid));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credits  <= CW'(`MM_TX_CREDITS);
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= send;
      case ({tx_valid, tx_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;   // none, or one used and one returned
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send) tx_data <= char_in;
  end

  // the receiver never hands back more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!reset_n)
    credits <= CW'(`MM_TX_CREDITS))
    else $error("credit count %0h above limit", credits);

  a_valid_credit: assert property (@(posedge clk) disable iff (!reset_n)
    tx_valid |-> credits != '0)
    else $error("tx_valid with no credit left");

endmodule

`default_nettype wire

// File: hw/dot_product_array.sv
`default_nettype none

`include "matmul_macros.svh"

module dot_product_array (
  input  wire logic    clk,
  input  wire logic    reset_n,
  operand_if.sink      op,
  col_result_if.source res
);
  import matmul_pkg::*;

  prod_t    prod [`MM_N][`MM_N];   // [row][k]
  logic     s1_valid;
  col_idx_t s1_col;
  sum_t     row_acc [`MM_N];

  // ---------------------------------------------------------------------------
  // stage 1 registers the sixteen products
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (op.valid) begin
      for (int r = 0; r < `MM_N; r++) begin
        for (int k = 0; k < `MM_N; k++) begin
          prod[r][k] <= op.a_mat[r][k] * op.b_col[k];
        end
      end
      s1_col <= op.col;
    end
  end

  // ---------------------------------------------------------------------------
  // stage 2 registers the row sums
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int r = 0; r < `MM_N; r++) begin
      row_acc[r] = '0;
      for (int k = 0; k < `MM_N; k++) begin
        row_acc[r] = row_acc[r] + sum_t'(prod[r][k]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res.sums <= row_acc;
      res.col  <= s1_col;
    end
  end

  // valid runs beside the data, so a new column may enter every cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      s1_valid  <= 1'b0;
      res.valid <= 1'b0;
    end else begin
      s1_valid  <= op.valid;
      res.valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

// File: hw/matmul_ctrl.sv
`default_nettype none

`include "matmul_macros.svh"

module matmul_ctrl (
  input  wire logic clk,
  input  wire logic reset_n,
  input  wire logic start,
  input  wire logic addr_at_last,   // address 31 is on the memory port
  input  wire logic text_at_last,   // every byte of the report has been sent
  input  wire logic can_send,
  input  wire logic col_done,       // fourth column result is stored
  output logic      addr_clear,
  output logic      addr_step,
  output logic      text_clear,
  output logic      send,
  output logic      mem_rd_en,
  output logic      busy,
  output logic      done
);
  import matmul_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic [$clog2(`MM_A_WORDS)-1:0] a_cnt;   // reads issued in LOAD_A

  // ---------------------------------------------------------------------------
  // state register and next-state logic
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= IDLE;
      a_cnt <= '0;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      a_cnt <= (state == LOAD_A) ? a_cnt + 1'b1 : '0;
      done  <= (state == PRINT) && text_at_last;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:   if (start) state_nxt = LOAD_A;
      LOAD_A: if (a_cnt == ($bits(a_cnt))'(`MM_A_WORDS - 1)) state_nxt = LOAD_B;
      LOAD_B: if (addr_at_last) state_nxt = DRAIN;
      DRAIN:  if (col_done) state_nxt = PRINT;
      PRINT:  if (text_at_last) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  // outputs
  assign mem_rd_en  = (state == LOAD_A) || (state == LOAD_B);   // one read per cycle
  assign addr_clear = (state == IDLE);
  assign addr_step  = mem_rd_en && !addr_at_last;
  assign text_clear = (state == IDLE);
  assign send       = (state == PRINT) && can_send && !text_at_last;
  assign busy       = (state != IDLE);

endmodule

`default_nettype wire

// File: hw/matmul_ifs.sv
`default_nettype none

`include "matmul_macros.svh"

// one B column together with the whole A matrix
interface operand_if;
  import matmul_pkg::*;

  logic     valid;                  // single-cycle pulse per column
  col_idx_t col;
  elem_t    a_mat [`MM_N][`MM_N];   // [row][k]
  elem_t    b_col [`MM_N];

  modport source (output valid, col, a_mat, b_col);
  modport sink   (input  valid, col, a_mat, b_col);
endinterface

// one finished column of C
interface col_result_if;
  import matmul_pkg::*;

  logic     valid;
  col_idx_t col;
  sum_t     sums [`MM_N];           // indexed by row

  modport source (output valid, col, sums);
  modport sink   (input  valid, col, sums);
endinterface

`default_nettype wire

// File: hw/matmul_macros.svh
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// ---------------------------------------------------------------------------
// matrix geometry and memory map
// ---------------------------------------------------------------------------
`define MM_N          4    // matrix dimension
`define MM_A_WORDS    16   // words of A stored column-major from address 0
`define MM_MEM_WORDS  32   // A followed by the four B columns

// ---------------------------------------------------------------------------
// report layout
// ---------------------------------------------------------------------------
`define MM_TEXT_LEN   166  // header + four lines + closing CR LF
`define MM_HDR_LEN    36
`define MM_LINE_LEN   32   // CR LF "[ xxxxx, xxxxx, xxxxx, xxxxx ]"
`define MM_HEX_DIGITS 5    // an 18-bit result needs five digits

// byte stream
`define MM_TX_CREDITS 4    // credits held by the sender after reset

`endif

// File: hw/matmul_pkg.sv
`default_nettype none

`include "matmul_macros.svh"

package matmul_pkg;

  // operands and arithmetic
  typedef logic [7:0] elem_t;                          // unsigned operand
  typedef logic [2*$bits(elem_t)-1:0] prod_t;          // full product

  // sum of N products needs two extra bits for N = 4
  typedef logic [$bits(prod_t)+$clog2(`MM_N)-1:0] sum_t;

  // addressing and positions
  typedef logic [$clog2(`MM_MEM_WORDS)-1:0] mem_addr_t;
  typedef logic [$clog2(`MM_TEXT_LEN+1)-1:0] text_idx_t;  // also holds the end count
  typedef logic [$clog2(`MM_N)-1:0] col_idx_t;

  // main sequencer
  typedef enum logic [2:0] {
    IDLE,
    LOAD_A,
    LOAD_B,
    DRAIN,
    PRINT
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/matmul_top.sv
`default_nettype none

`include "matmul_macros.svh"

module matmul_top (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire logic                  start,
  // external read-only memory with one cycle latency
  output logic                       mem_rd_en,
  output matmul_pkg::mem_addr_t      mem_addr,
  input  wire matmul_pkg::elem_t     mem_rdata,
  // credit-based byte stream
  output logic                       tx_valid,
  output logic [7:0]                 tx_data,
  input  wire logic                  tx_credit,
  output logic                       busy,
  output logic                       done
);
  import matmul_pkg::*;

  logic      addr_clear;
  logic      addr_step;
  logic      addr_at_last;
  logic      text_clear;
  logic      text_at_last;
  logic      send;
  logic      can_send;
  logic      col_done;
  text_idx_t text_idx;
  logic [7:0] text_char;

  operand_if    op_if ();
  col_result_if res_if ();

  // ---------------------------------------------------------------------------
  // sequencing
  // ---------------------------------------------------------------------------
  seq_counter #(.WIDTH($bits(mem_addr_t))) addr_cnt_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .clear      (addr_clear),
    .step       (addr_step),
    .last_value (mem_addr_t'(`MM_MEM_WORDS - 1)),
    .count      (mem_addr),
    .at_last    (addr_at_last)
  );

  seq_counter #(.WIDTH($bits(text_idx_t))) text_cnt_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .clear      (text_clear),
    .step       (send),
    .last_value (text_idx_t'(`MM_TEXT_LEN)),   // count of bytes already sent
    .count      (text_idx),
    .at_last    (text_at_last)
  );

  matmul_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .addr_at_last (addr_at_last),
    .text_at_last (text_at_last),
    .can_send     (can_send),
    .col_done     (col_done),
    .addr_clear   (addr_clear),
    .addr_step    (addr_step),
    .text_clear   (text_clear),
    .send         (send),
    .mem_rd_en    (mem_rd_en),
    .busy         (busy),
    .done         (done)
  );

  // ---------------------------------------------------------------------------
  // datapath
  // ---------------------------------------------------------------------------
  operand_loader loader_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_rd_en (mem_rd_en),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .op        (op_if.source)
  );

  dot_product_array dot_i (
    .clk     (clk),
    .reset_n (reset_n),
    .op      (op_if.sink),
    .res     (res_if.source)
  );

  result_text text_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .res       (res_if.sink),
    .text_idx  (text_idx),
    .col_done  (col_done),
    .text_char (text_char)
  );

  byte_credit_tx tx_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .send      (send),
    .char_in   (text_char),
    .tx_credit (tx_credit),
    .can_send  (can_send),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data)
  );

endmodule

`default_nettype wire

// File: hw/operand_loader.sv
`default_nettype none

`include "matmul_macros.svh"

module operand_loader (
  input  wire logic                 clk,
  input  wire logic                 reset_n,
  input  wire logic                 mem_rd_en,
  input  wire matmul_pkg::mem_addr_t mem_addr,
  input  wire matmul_pkg::elem_t    mem_rdata,
  operand_if.source                 op
);
  import matmul_pkg::*;

  localparam int KW = $clog2(`MM_N);
  localparam logic [KW-1:0] LAST_K = KW'(`MM_N - 1);

  logic      rd_en_q;           // read data is on mem_rdata this cycle
  mem_addr_t addr_q;            // address that data belongs to
  elem_t     b_part [`MM_N-1];  // first three words of the current column
  logic      in_a;

  always_ff @(posedge clk) begin
    if (!reset_n) rd_en_q <= 1'b0;
    else          rd_en_q <= mem_rd_en;
  end

  always_ff @(posedge clk) begin
    addr_q <= mem_addr;
  end

  assign in_a = (addr_q < mem_addr_t'(`MM_A_WORDS));

  // word k of A is A[k mod N][k div N]
  always_ff @(posedge clk) begin
    if (rd_en_q && in_a) op.a_mat[addr_q[KW-1:0]][addr_q[2*KW-1:KW]] <= mem_rdata;
    if (rd_en_q && !in_a && addr_q[KW-1:0] != LAST_K) b_part[addr_q[KW-1:0]] <= mem_rdata;
  end

  always_comb begin
    for (int k = 0; k < `MM_N - 1; k++) begin
      op.b_col[k] = b_part[k];
    end
    op.b_col[`MM_N-1] = mem_rdata;    // last word passes straight through
  end

  assign op.valid = rd_en_q && !in_a && (addr_q[KW-1:0] == LAST_K);
  assign op.col   = addr_q[2*KW-1:KW];   // (addr - 16) div 4

endmodule

`default_nettype wire

// File: hw/result_text.sv
`default_nettype none

`include "matmul_macros.svh"

module result_text (
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  col_result_if.sink                 res,
  input  wire matmul_pkg::text_idx_t text_idx,
  output logic                       col_done,
  output logic [7:0]                 text_char
);
  import matmul_pkg::*;

  localparam int FIELD_LEN = `MM_HEX_DIGITS + 2;   // digits and a two-char separator
  localparam int FIELD_OFS = 4;                    // CR LF "[ "
  localparam logic [8*`MM_HDR_LEN-1:0] HEADER = "The matrix multiplication result is:";
  localparam logic [7:0] CR = 8'h0d;
  localparam logic [7:0] LF = 8'h0a;

  sum_t      results [`MM_N][`MM_N];   // [row][col]
  text_idx_t body_pos;
  text_idx_t line_num;
  text_idx_t line_pos;
  text_idx_t field_pos;
  text_idx_t field_num;
  text_idx_t digit_pos;
  logic [$clog2(`MM_N)-1:0] row_sel;
  col_idx_t  field_col;
  logic [4*`MM_HEX_DIGITS-1:0] field_val;
  logic [3:0] nibble;

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    if (nib < 4'd10) return 8'("0") + {4'h0, nib};
    return 8'("A") - 8'd10 + {4'h0, nib};
  endfunction

  // ---------------------------------------------------------------------------
  // result store
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (res.valid) begin
      for (int r = 0; r < `MM_N; r++) begin
        results[r][res.col] <= res.sums[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) col_done <= 1'b0;
    else          col_done <= res.valid && (res.col == col_idx_t'(`MM_N - 1));
  end

  // ---------------------------------------------------------------------------
  // text position decode
  // ---------------------------------------------------------------------------
  assign body_pos  = text_idx - text_idx_t'(`MM_HDR_LEN);
  assign line_num  = body_pos / text_idx_t'(`MM_LINE_LEN);   // 4 is the closing CR LF
  assign line_pos  = body_pos % text_idx_t'(`MM_LINE_LEN);
  assign field_pos = line_pos - text_idx_t'(FIELD_OFS);
  assign field_num = field_pos / text_idx_t'(FIELD_LEN);
  assign digit_pos = field_pos % text_idx_t'(FIELD_LEN);
  assign row_sel   = line_num[$bits(row_sel)-1:0];
  assign field_col = field_num[$bits(field_col)-1:0];

  // msd first, top digit only has two live bits
  assign field_val = ($bits(field_val))'(results[row_sel][field_col]);
  assign nibble    = 4'(field_val >> (4 * (`MM_HEX_DIGITS - 1 - digit_pos)));

  always_comb begin
    text_char = LF;
    if (text_idx < text_idx_t'(`MM_HDR_LEN)) begin
      text_char = HEADER[8 * (`MM_HDR_LEN - 1 - text_idx) +: 8];
    end else if (line_num >= text_idx_t'(`MM_N)) begin
      text_char = (line_pos == '0) ? CR : LF;
    end else if (line_pos == text_idx_t'(0)) begin
      text_char = CR;
    end else if (line_pos == text_idx_t'(1)) begin
      text_char = LF;
    end else if (line_pos == text_idx_t'(2)) begin
      text_char = "[";
    end else if (line_pos == text_idx_t'(3)) begin
      text_char = " ";
    end else if (digit_pos < text_idx_t'(`MM_HEX_DIGITS)) begin
      text_char = hex_char(nibble);
    end else if (digit_pos == text_idx_t'(`MM_HEX_DIGITS)) begin
      text_char = (field_col == col_idx_t'(`MM_N - 1)) ? " " : ",";
    end else begin
      text_char = (field_col == col_idx_t'(`MM_N - 1)) ? "]" : " ";
    end
  end

endmodule

`default_nettype wire

// File: hw/seq_counter.sv
`default_nettype none

module seq_counter #(
  parameter int WIDTH = 8
) (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire logic             clear,
  input  wire logic             step,
  input  wire logic [WIDTH-1:0] last_value,
  output logic      [WIDTH-1:0] count,
  output logic                  at_last
);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

  assign at_last = (count == last_value);

  // the sequencer must stop stepping once the final value is reached
  a_no_overrun: assert property (@(posedge clk) disable iff (!reset_n)
    (step && !clear) |-> !at_last)
    else $error("seq_counter stepped past last_value %0h", last_value);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the matrix multiplier testbench with Verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_matmul_top -f flist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
grep -q "TEST OK" sim.log
echo "simulation passed"

// File: test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------------------------------
// expected report built from the words in the memory model
// --------------------------------------------------------------------------
function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
  if (nib < 4'd10) return 8'h30 + {4'h0, nib};
  return 8'h37 + {4'h0, nib};   // 10 maps to 'A'
endfunction

function automatic void add_char(input logic [7:0] ch);
  exp_text[exp_len] = ch;
  exp_len++;
endfunction

function automatic void build_expected_text();
  string hdr;
  int    c_val;
  hdr = "The matrix multiplication result is:";
  exp_len = 0;
  for (int i = 0; i < hdr.len(); i++) begin
    add_char(hdr[i]);
  end
  for (int r = 0; r < `MM_N; r++) begin
    add_char(8'h0d);
    add_char(8'h0a);
    add_char("[");
    add_char(" ");
    for (int c = 0; c < `MM_N; c++) begin
      c_val = 0;
      // A[r][k] sits at r + 4k and Bc[k] at 16 + 4c + k
      for (int k = 0; k < `MM_N; k++) begin
        c_val += int'(mem[r + `MM_N * k]) * int'(mem[`MM_A_WORDS + `MM_N * c + k]);
      end
      for (int d = `MM_HEX_DIGITS - 1; d >= 0; d--) begin
        add_char(hex_ascii(4'(c_val >> (4 * d))));
      end
      add_char((c == `MM_N - 1) ? " " : ",");
      add_char((c == `MM_N - 1) ? "]" : " ");
    end
  end
  add_char(8'h0d);
  add_char(8'h0a);
endfunction

// --------------------------------------------------------------------------
// protocol and data checks
// --------------------------------------------------------------------------
a_reset_idle: assert property (@(posedge clk)
  !reset_n |=> !busy && !done && !tx_valid && !mem_rd_en)
  else begin
    errors++;
    $display("busy, done, tx_valid or mem_rd_en not low after reset");
  end

a_quiet_before_start: assert property (@(posedge clk) disable iff (!reset_n)
  !started |-> !tx_valid)
  else begin
    errors++;
    $display("tx_valid went high before any start");
  end

a_addr_order: assert property (@(posedge clk) disable iff (!reset_n)
  mem_rd_en |-> rd_count < `MM_MEM_WORDS && mem_addr == mem_addr_t'(rd_count))
  else begin
    errors++;
    $display("CHECK FAILED mem_addr: got %h expected %h", $sampled(mem_addr),
             $sampled(rd_count));
  end

a_read_count: assert property (@(posedge clk) disable iff (!reset_n)
  $fell(mem_rd_en) |-> rd_count == `MM_MEM_WORDS)
  else begin
    errors++;
    $display("CHECK FAILED rd_count: got %h expected %h", $sampled(rd_count),
             `MM_MEM_WORDS);
  end

a_credit_limit: assert property (@(posedge clk) disable iff (!reset_n)
  outstanding <= `MM_TX_CREDITS)
  else begin
    errors++;
    $display("more than %0d bytes outstanding without credit", `MM_TX_CREDITS);
  end

a_valid_credit: assert property (@(posedge clk) disable iff (!reset_n)
  tx_valid |-> outstanding < `MM_TX_CREDITS)
  else begin
    errors++;
    $display("tx_valid high while no credit was left");
  end

a_byte_value: assert property (@(posedge clk) disable iff (!reset_n)
  tx_valid |-> byte_idx < `MM_TEXT_LEN && tx_data == exp_text[byte_idx])
  else begin
    errors++;
    $display("CHECK FAILED tx_data at byte %0d: got %h expected %h", $sampled(byte_idx),
             $sampled(tx_data), exp_text[$sampled(byte_idx)]);
  end

a_busy_rise: assert property (@(posedge clk) disable iff (!reset_n)
  start && !busy |=> busy)
  else begin
    errors++;
    $display("busy did not rise in the cycle after start");
  end

a_busy_fall: assert property (@(posedge clk) disable iff (!reset_n)
  $fell(busy) |-> done)
  else begin
    errors++;
    $display("busy fell without done");
  end

a_done_idle: assert property (@(posedge clk) disable iff (!reset_n)
  done |-> !busy)
  else begin
    errors++;
    $display("busy still high while done was pulsed");
  end

a_done_end: assert property (@(posedge clk) disable iff (!reset_n)
  done |-> byte_idx == `MM_TEXT_LEN)
  else begin
    errors++;
    $display("CHECK FAILED byte_idx at done: got %h expected %h", $sampled(byte_idx),
             `MM_TEXT_LEN);
  end

a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
  done |=> !done)
  else begin
    errors++;
    $display("done was high for more than one cycle");
  end

`endif

// File: test/tb_matmul_top.sv
`default_nettype none

`include "matmul_macros.svh"

module tb_matmul_top;
  timeunit 1ns;
  timeprecision 100ps;
  import matmul_pkg::*;

  localparam int RUNS = 3;
  localparam int WATCHDOG_CYCLES = RUNS * (40 + `MM_TEXT_LEN * 9) + 500;

  logic       clk = 1'b0;
  logic       reset_n = 1'b0;
  logic       start = 1'b0;
  logic       mem_rd_en;
  mem_addr_t  mem_addr;
  elem_t      mem_rdata = '0;
  logic       tx_credit = 1'b0;
  logic       tx_valid;
  logic [7:0] tx_data;
  logic       busy;
  logic       done;

  elem_t       mem [`MM_MEM_WORDS];
  logic [7:0]  exp_text [`MM_TEXT_LEN];
  int          exp_len = 0;
  logic [31:0] lcg_state = 32'h43ec;
  int          errors = 0;
  logic        started = 1'b0;
  int          cycle = 0;
  int          rd_count = 0;      // reads in the current run
  int          byte_idx = 0;      // bytes received in the current run
  int          outstanding = 0;   // bytes not yet given back as credit
  int          credit_due [$];    // cycle numbers for pending credit pulses
  int          last_due = -1;
  int          due;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  `include "tb_checks.svh"

  matmul_top dut_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .mem_rd_en (mem_rd_en),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_credit (tx_credit),
    .busy      (busy),
    .done      (done)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // --------------------------------------------------------------------------
  // memory model and credit-returning sink
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (mem_rd_en) mem_rdata <= mem[mem_addr];   // one cycle read latency
  end

  always @(posedge clk) begin
    if (!reset_n) begin
      tx_credit   <= 1'b0;
      outstanding <= 0;
    end else begin
      tx_credit   <= 1'b0;
      outstanding <= outstanding + int'(tx_valid) - int'(tx_credit);
      if (tx_valid) begin
        due = cycle + int'((lcg_next() >> 16) % 8);
        if (due <= last_due) due = last_due + 1;   // at most one pulse per cycle
        last_due = due;
        credit_due.push_back(due);
      end
      if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
        tx_credit <= 1'b1;
        void'(credit_due.pop_front());
      end
    end
  end

  // per-run counters that clear when a start is accepted
  always @(posedge clk) begin
    if (start && !busy) begin
      rd_count <= 0;
      byte_idx <= 0;
    end else begin
      if (mem_rd_en) rd_count <= rd_count + 1;
      if (tx_valid) byte_idx <= byte_idx + 1;
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  task automatic fill_random();
    for (int i = 0; i < `MM_MEM_WORDS; i++) begin
      mem[i] = elem_t'(lcg_next() >> 24);
    end
  endtask

  task automatic fill_ones();
    for (int i = 0; i < `MM_MEM_WORDS; i++) begin
      mem[i] = 8'hff;   // every result is 3F804
    end
  endtask

  task automatic run_matmul();
    build_expected_text();
    @(posedge clk);
    start   <= 1'b1;
    started <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (5) @(posedge clk);
    start <= 1'b1;   // must be ignored while busy
    @(posedge clk);
    start <= 1'b0;
    while (!done) @(posedge clk);
  endtask

  initial begin
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    fill_random();
    run_matmul();
    fill_ones();
    run_matmul();
    fill_random();
    run_matmul();
    repeat (4) @(posedge clk);
    $display("%0d runs finished, %0d error(s)", RUNS, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the last run finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
